//--- files.f
src/fb_pkg.sv
src/mem_arbiter.sv
src/frame_store.sv
src/frame_fetch.sv
src/pixel_fifo.sv
src/scan_timing.sv
src/display_top.sv
testbench/tb_clock.sv
testbench/display_sva.sv
testbench/display_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module display_tb \
	-Mdir obj_dir -o display_sim -f files.f

out=$(./obj_dir/display_sim)
echo "$out"

if echo "$out" | grep -qF '** PASS **'; then
	exit 0
fi
exit 1

//--- testbench/display_tb.sv
`timescale 1ns/1ps

module display_tb import fb_pkg::*;
();

	localparam int FRAME_PIX   = H_ACTIVE * V_ACTIVE;
	localparam int FRAME_CLKS  = H_TOTAL * V_TOTAL * PIX_DIV;
	localparam int WR_TIMEOUT  = 20;
	localparam int N_TESTS     = 5;

	logic      clk;
	logic      rst;
	logic      display_en;
	logic      host_valid;
	mem_addr_t host_addr;
	mem_word_t host_wdata;
	logic      host_ready;
	pixel_t    pixel;
	sync_t     sync;
	logic      underrun;
	logic      frame_done;

	logic [7:0] model [0:FRAME_PIX-1]; // Low byte per lane, word-major
	int    errs [1:N_TESTS] = '{default: 0};
	int    mon_errs [1:N_TESTS] = '{default: 0};
	int    passed = 0;
	bit    mon_on = 1'b0;
	int    pix_n = 0;
	int    de_cycles = 0;
	int    de_frame = 0;
	int    h_len = 0;
	int    v_len = 0;
	int    line_cnt = 0;
	int    vsync_rises = 0;
	int    word_cnt = 0;
	int    done_cnt = 0;
	int    ready_pulses = 0;
	sync_t prev_sync = '0;

	tb_clock u_clock (.clk(clk));

	display_top dut (
		.clk        (clk),
		.rst        (rst),
		.display_en (display_en),
		.host_valid (host_valid),
		.host_addr  (host_addr),
		.host_wdata (host_wdata),
		.host_ready (host_ready),
		.pixel      (pixel),
		.sync       (sync),
		.underrun   (underrun),
		.frame_done (frame_done)
	);

	function automatic int show_mismatch(input string sig, input int exp, input int act);
		$display("MISMATCH t=%0t %s expected=0x%0h got=0x%0h", $time, sig, exp, act);
		return 1;
	endfunction

	function automatic int show_failure(input string msg);
		$display("ERROR t=%0t %s", $time, msg);
		return 1;
	endfunction

	task automatic report_test(input int k, input string name, input bit ran);
		if (!ran)
			$display("test %0d %s: not run", k, name);
		else if (errs[k] + mon_errs[k] == 0)
		begin
			$display("test %0d %s: ok", k, name);
			passed++;
		end
		else
			$display("test %0d %s: failed, %0d errors", k, name, errs[k] + mon_errs[k]);
	endtask

	// Outputs are settled at the falling edge
	always @(negedge clk)
	begin
		int idx;
		if (host_ready)
			ready_pulses++;
		if (mon_on)
		begin
			// First cycle of each pixel
			if (sync.de && de_cycles % PIX_DIV == 0)
			begin
				idx = pix_n % FRAME_PIX;
				assert (pixel == {3{model[idx]}})
				else mon_errs[3] += show_mismatch("pixel", int'({3{model[idx]}}), int'(pixel));
				assert (pixel.r == pixel.g && pixel.g == pixel.b)
				else mon_errs[3] += show_mismatch("pixel.b", int'(pixel.r), int'(pixel.b));
				pix_n++;
			end
			if (sync.de)
			begin
				de_cycles++;
				de_frame++;
			end
			if (sync.hsync)
				h_len++;
			else if (prev_sync.hsync)
			begin
				assert (h_len == H_SYNC * PIX_DIV)
				else mon_errs[4] += show_mismatch("sync.hsync cycles", H_SYNC * PIX_DIV, h_len);
				h_len = 0;
				line_cnt++;
			end
			if (sync.vsync && !prev_sync.vsync)
			begin
				assert (de_frame == FRAME_PIX * PIX_DIV)
				else mon_errs[4] += show_mismatch("sync.de cycles", FRAME_PIX * PIX_DIV, de_frame);
				if (vsync_rises > 0)
				begin
					assert (line_cnt == V_TOTAL)
					else mon_errs[4] += show_mismatch("lines per frame", V_TOTAL, line_cnt);
				end
				de_frame = 0;
				line_cnt = 0;
				vsync_rises++;
			end
			if (sync.vsync)
				v_len++;
			else if (prev_sync.vsync)
			begin
				assert (v_len == V_SYNC * H_TOTAL * PIX_DIV)
				else mon_errs[4] += show_mismatch("sync.vsync cycles", V_SYNC * H_TOTAL * PIX_DIV,
					v_len);
				v_len = 0;
			end
			if (dut.rd_valid && dut.rd_ready)
				word_cnt++;
			if (frame_done)
			begin
				assert (word_cnt == FRAME_WORDS)
				else mon_errs[5] += show_mismatch("words per frame_done", FRAME_WORDS, word_cnt);
				word_cnt = 0;
				done_cnt++;
			end
		end
		prev_sync = sync;
	end

	initial
	begin
		bit          ok;
		int          t;
		mem_word_t   word;
		logic [31:0] lane_val;
		void'($urandom(91));
		rst        = 1'b1;
		display_en = 1'b0;
		host_valid = 1'b0;
		host_addr  = '0;
		host_wdata = '0;
		word       = '0;
		repeat (10) @(posedge clk);
		rst <= 1'b0;

		repeat (4)
		begin
			@(negedge clk);
			assert (!host_ready && sync == '0 && pixel == '0 && !underrun && !frame_done)
			else errs[1] += show_failure("an output is not low after reset");
		end
		report_test(1, "reset state", 1'b1);

		ok = 1'b1;
		for (int w = 0; w < FRAME_WORDS && ok; w++)
		begin
			for (int l = 0; l < PIX_PER_WORD; l++)
			begin
				lane_val = $urandom();
				word[l*LANE_W +: LANE_W] = lane_val;
				model[w*PIX_PER_WORD + l] = lane_val[7:0];
			end
			@(posedge clk);
			host_valid <= 1'b1;
			host_addr  <= mem_addr_t'(w);
			host_wdata <= word;
			@(negedge clk);
			t = 0;
			while (!host_ready && t < WR_TIMEOUT)
			begin
				@(negedge clk);
				t++;
			end
			if (!host_ready)
			begin
				errs[2] += show_failure("host write got no host_ready in time");
				ok = 1'b0;
			end
		end
		@(posedge clk);
		host_valid <= 1'b0;
		@(posedge clk);
		assert (ready_pulses == FRAME_WORDS)
		else errs[2] += show_mismatch("host_ready pulses", FRAME_WORDS, ready_pulses);
		report_test(2, "host writes", 1'b1);

		if (ok)
		begin
			display_en <= 1'b1;
			mon_on     <= 1'b1;
			for (int f = 1; f <= 3 && ok; f++)
			begin
				t = 0;
				while (vsync_rises < f && t < 3 * FRAME_CLKS)
				begin
					@(posedge clk);
					t++;
				end
				if (vsync_rises < f)
				begin
					errs[4] += show_failure("no vsync pulse within the frame timeout");
					ok = 1'b0;
				end
			end
			mon_on <= 1'b0;
			assert (pix_n >= 2 * FRAME_PIX)
			else errs[3] += show_mismatch("pixels checked", 2 * FRAME_PIX, pix_n);
			assert (!underrun)
			else errs[5] += show_mismatch("underrun", 0, 1);
			assert (done_cnt >= 3)
			else errs[5] += show_mismatch("frame_done pulses", 3, done_cnt);
		end
		report_test(3, "pixel order and value", ok);
		report_test(4, "sync geometry", ok);
		report_test(5, "back-pressure and continuity", ok);

		$display("tests: %0d run, %0d passed, %0d failed", N_TESTS, passed, N_TESTS - passed);
		if (passed == N_TESTS)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

//--- testbench/display_sva.sv
`timescale 1ns/1ps

module display_sva import fb_pkg::*;
(
	input logic      clk,
	input logic      rst,
	input logic      host_valid,
	input logic      host_ready,
	input logic      rd_valid,
	input mem_addr_t rd_addr,
	input logic      rd_ready,
	input logic      push,
	input logic      fifo_full,
	input pixel_t    pixel,
	input sync_t     sync,
	input logic      underrun,
	input logic      frame_done
);

	// All outputs quiet in the cycle after a reset cycle
	a_reset_quiet: assert property (@(posedge clk)
		rst |=> !host_ready && sync == '0 && pixel == '0 && !underrun && !frame_done)
		else $error("output not low after reset");

	a_host_ready: assert property (@(posedge clk) disable iff (rst)
		host_ready |-> host_valid)
		else $error("host_ready without host_valid");

	a_rd_hold: assert property (@(posedge clk) disable iff (rst)
		rd_valid && !rd_ready |=> rd_valid && $stable(rd_addr))
		else $error("read request dropped or address changed before rd_ready");

	a_push_full: assert property (@(posedge clk) disable iff (rst)
		push |-> !fifo_full)
		else $error("push into a full pixel FIFO");

	a_de_hsync: assert property (@(posedge clk) disable iff (rst)
		!(sync.de && sync.hsync))
		else $error("de and hsync high together");

endmodule

bind display_top display_sva u_sva (
	.clk        (clk),
	.rst        (rst),
	.host_valid (host_valid),
	.host_ready (host_ready),
	.rd_valid   (rd_valid),
	.rd_addr    (rd_addr),
	.rd_ready   (rd_ready),
	.push       (push),
	.fifo_full  (fifo_full),
	.pixel      (pixel),
	.sync       (sync),
	.underrun   (underrun),
	.frame_done (frame_done)
);

//--- testbench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock
(
	output logic clk
);

	initial clk = 1'b0;

	always #2 clk = ~clk; // 4 ns period

endmodule

//--- src/display_top.sv
`timescale 1ns/1ps

module display_top import fb_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      display_en,
	input  logic      host_valid,
	input  mem_addr_t host_addr,
	input  mem_word_t host_wdata,
	output logic      host_ready,
	output pixel_t    pixel,
	output sync_t     sync,
	output logic      underrun,
	output logic      frame_done
);

	// Fetch read port
	logic      rd_valid;
	mem_addr_t rd_addr;
	logic      rd_ready;
	mem_word_t rd_data;

	// Store side
	logic      req_valid;
	mem_req_t  req;
	logic      resp_valid;
	mem_word_t resp_data;

	// Pixel FIFO
	logic      push;
	pixel_t    push_pixel;
	logic      pop;
	pixel_t    pop_pixel;
	logic      fifo_full;
	logic      fifo_empty;

	mem_arbiter u_arbiter (
		.clk        (clk),
		.rst        (rst),
		.rd_valid   (rd_valid),
		.rd_addr    (rd_addr),
		.rd_ready   (rd_ready),
		.rd_data    (rd_data),
		.host_valid (host_valid),
		.host_addr  (host_addr),
		.host_wdata (host_wdata),
		.host_ready (host_ready),
		.req_valid  (req_valid),
		.req        (req),
		.resp_valid (resp_valid),
		.resp_data  (resp_data)
	);

	frame_store u_store (
		.clk        (clk),
		.rst        (rst),
		.req_valid  (req_valid),
		.req        (req),
		.resp_valid (resp_valid),
		.resp_data  (resp_data)
	);

	frame_fetch u_fetch (
		.clk        (clk),
		.rst        (rst),
		.display_en (display_en),
		.rd_valid   (rd_valid),
		.rd_addr    (rd_addr),
		.rd_ready   (rd_ready),
		.rd_data    (rd_data),
		.fifo_full  (fifo_full),
		.push       (push),
		.push_pixel (push_pixel),
		.last_word  (frame_done) // One pulse per fetched frame
	);

	pixel_fifo u_fifo (
		.clk        (clk),
		.rst        (rst),
		.push       (push),
		.push_pixel (push_pixel),
		.pop        (pop),
		.pop_pixel  (pop_pixel),
		.full       (fifo_full),
		.empty      (fifo_empty)
	);

	scan_timing u_scan (
		.clk        (clk),
		.rst        (rst),
		.display_en (display_en),
		.fifo_full  (fifo_full),
		.fifo_empty (fifo_empty),
		.fifo_pixel (pop_pixel),
		.pop        (pop),
		.pixel      (pixel),
		.sync       (sync),
		.underrun   (underrun)
	);

endmodule

//--- src/scan_timing.sv
`timescale 1ns/1ps

module scan_timing import fb_pkg::*;
(
	input  logic   clk,
	input  logic   rst,
	input  logic   display_en,
	input  logic   fifo_full,
	input  logic   fifo_empty,
	input  pixel_t fifo_pixel,
	output logic   pop,
	output pixel_t pixel,
	output sync_t  sync,
	output logic   underrun
);

	logic               started; // Prefill done
	logic [DIV_W-1:0]   div;
	logic [H_CNT_W-1:0] h_cnt;
	logic [V_CNT_W-1:0] v_cnt;
	logic               strobe;
	logic               active;
	logic               h_sync_on;
	logic               v_sync_on;
	logic               line_end;
	logic               frame_end;

	assign strobe = started & (div == DIV_W'(PIX_DIV - 1));
	assign active = (h_cnt < H_CNT_W'(H_ACTIVE)) & (v_cnt < V_CNT_W'(V_ACTIVE));

	assign h_sync_on = (h_cnt >= H_CNT_W'(H_ACTIVE + H_FRONT)) &
		(h_cnt < H_CNT_W'(H_ACTIVE + H_FRONT + H_SYNC));
	assign v_sync_on = (v_cnt >= V_CNT_W'(V_ACTIVE + V_FRONT)) &
		(v_cnt < V_CNT_W'(V_ACTIVE + V_FRONT + V_SYNC));

	assign line_end  = (h_cnt == H_CNT_W'(H_TOTAL - 1));
	assign frame_end = (v_cnt == V_CNT_W'(V_TOTAL - 1));

	assign pop = strobe & active & ~fifo_empty;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			started  <= 1'b0;
			div      <= '0;
			h_cnt    <= '0;
			v_cnt    <= '0;
			sync     <= '0;
			pixel    <= '0;
			underrun <= 1'b0;
		end
		else
		begin
			if (~display_en)
				started <= 1'b0;
			else if (fifo_full)
				started <= 1'b1; // First full FIFO after enable

			if (~started)
			begin
				div   <= '0;
				h_cnt <= '0;
				v_cnt <= '0;
				sync  <= '0;
				pixel <= '0;
			end
			else
			begin
				div <= strobe ? '0 : div + 1'b1;
				if (strobe)
				begin
					sync.hsync <= h_sync_on;
					sync.vsync <= v_sync_on;
					sync.de    <= active;
					pixel      <= pop ? fifo_pixel : '0; // Black on underrun
					h_cnt      <= line_end ? '0 : h_cnt + 1'b1;
					if (line_end)
						v_cnt <= frame_end ? '0 : v_cnt + 1'b1;
				end
			end

			// Sticky until reset
			if (strobe & active & fifo_empty)
				underrun <= 1'b1;
		end
	end

endmodule

//--- src/pixel_fifo.sv
`timescale 1ns/1ps

module pixel_fifo import fb_pkg::*;
(
	input  logic   clk,
	input  logic   rst,
	input  logic   push,
	input  pixel_t push_pixel,
	input  logic   pop,
	output pixel_t pop_pixel,
	output logic   full,
	output logic   empty
);

	pixel_t                mem [0:FIFO_DEPTH-1];
	logic [FIFO_PTR_W-1:0] wr_ptr;
	logic [FIFO_PTR_W-1:0] rd_ptr;
	logic [FIFO_CNT_W-1:0] count;
	logic                  wr_en;
	logic                  rd_en;

	assign full  = (count == FIFO_CNT_W'(FIFO_DEPTH));
	assign empty = (count == '0);
	assign wr_en = push & ~full;
	assign rd_en = pop & ~empty;

	assign pop_pixel = mem[rd_ptr]; // First word out

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1; // Depth is a power of two
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[wr_ptr] <= push_pixel;
	end

endmodule

//--- src/frame_fetch.sv
`timescale 1ns/1ps

module frame_fetch import fb_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      display_en,
	output logic      rd_valid,
	output mem_addr_t rd_addr,
	input  logic      rd_ready,
	input  mem_word_t rd_data,
	input  logic      fifo_full,
	output logic      push,
	output pixel_t    push_pixel,
	output logic      last_word
);

	mem_word_t             hold_word; // Parked read response
	logic                  hold_full;
	mem_word_t             unp_word;  // Word being split into pixels
	logic                  unp_full;
	logic [LANE_SEL_W-1:0] lane;
	logic                  rd_done;
	logic                  last_lane;
	logic                  xfer;
	logic [7:0]            grey;

	assign rd_done   = rd_valid & rd_ready;
	assign push      = unp_full & ~fifo_full; // Full is the back-pressure
	assign last_lane = push & (lane == LANE_SEL_W'(PIX_PER_WORD - 1));

	// Hold to unpack move, also on the last push of the current word
	assign xfer = hold_full & (~unp_full | last_lane);

	// Low byte of the current lane, lane 0 first
	assign grey       = unp_word[lane * LANE_W +: 8];
	assign push_pixel = '{r: grey, g: grey, b: grey};

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rd_valid  <= 1'b0;
			rd_addr   <= '0;
			last_word <= 1'b0;
		end
		else
		begin
			last_word <= rd_done & (rd_addr == mem_addr_t'(FRAME_WORDS - 1));
			if (rd_done)
			begin
				rd_valid <= 1'b0;
				if (rd_addr == mem_addr_t'(FRAME_WORDS - 1))
					rd_addr <= '0; // Wrap to frame start
				else
					rd_addr <= rd_addr + 1'b1;
			end
			// Hold register is free, or frees this cycle
			else if (display_en & ~rd_valid & (~hold_full | xfer))
				rd_valid <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			hold_full <= 1'b0;
			unp_full  <= 1'b0;
			lane      <= '0;
		end
		else
		begin
			hold_full <= rd_done | (hold_full & ~xfer);
			if (xfer)
			begin
				unp_full <= 1'b1;
				lane     <= '0;
			end
			else if (last_lane)
			begin
				unp_full <= 1'b0;
				lane     <= '0;
			end
			else if (push)
				lane <= lane + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rd_done)
			hold_word <= rd_data;
		if (xfer)
			unp_word <= hold_word;
	end

endmodule

//--- src/frame_store.sv
`timescale 1ns/1ps

module frame_store import fb_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      req_valid,
	input  mem_req_t  req,
	output logic      resp_valid,
	output mem_word_t resp_data
);

	mem_word_t mem [0:(2**ADDR_W)-1];
	mem_word_t rd_stage; // First read stage
	logic      rd_v1;
	logic      rd_v2;
	logic      wr_ack;

	// Only one request in flight, so the two answers never collide
	assign resp_valid = rd_v2 | wr_ack;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rd_v1  <= 1'b0;
			rd_v2  <= 1'b0;
			wr_ack <= 1'b0;
		end
		else
		begin
			rd_v1  <= req_valid & ~req.we;
			rd_v2  <= rd_v1;
			wr_ack <= req_valid & req.we; // Write answered next cycle
		end
	end

	// Array and read pipeline data
	always_ff @(posedge clk)
	begin
		if (req_valid & req.we)
			mem[req.addr] <= req.wdata;
		if (req_valid & ~req.we)
			rd_stage <= mem[req.addr];
		resp_data <= rd_stage; // Second read stage
	end

endmodule

//--- src/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter import fb_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	// Fetch read port
	input  logic      rd_valid,
	input  mem_addr_t rd_addr,
	output logic      rd_ready,
	output mem_word_t rd_data,
	// Host write port
	input  logic      host_valid,
	input  mem_addr_t host_addr,
	input  mem_word_t host_wdata,
	output logic      host_ready,
	// Frame store side
	output logic      req_valid,
	output mem_req_t  req,
	input  logic      resp_valid,
	input  mem_word_t resp_data
);

	logic busy;     // Request in the store
	logic last_rd;  // Fetch port was served last, also owns the current grant
	logic gnt_rd;

	// Fetch wins unless the host waits too and fetch had the last turn
	assign gnt_rd    = rd_valid & (~host_valid | ~last_rd);
	assign req_valid = ~busy & (rd_valid | host_valid);

	always_comb
	begin
		req.we    = ~gnt_rd;
		req.addr  = gnt_rd ? rd_addr : host_addr;
		req.wdata = host_wdata; // Ignored on reads
	end

	// Response goes back to whoever holds the grant
	assign rd_ready   = resp_valid & last_rd;
	assign host_ready = resp_valid & ~last_rd;
	assign rd_data    = resp_data;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			busy    <= 1'b0;
			last_rd <= 1'b0;
		end
		else if (req_valid)
		begin
			busy    <= 1'b1;
			last_rd <= gnt_rd;
		end
		else if (resp_valid)
			busy <= 1'b0; // Grant held until here
	end

endmodule

//--- src/fb_pkg.sv
package fb_pkg;

	// Active area, cut down for short simulation
	localparam int H_ACTIVE = 32;
	localparam int V_ACTIVE = 4;

	// Blanking in pixels and in lines
	localparam int H_FRONT = 2;
	localparam int H_SYNC  = 4;
	localparam int H_BACK  = 2;
	localparam int V_FRONT = 1;
	localparam int V_SYNC  = 1;
	localparam int V_BACK  = 1;

	localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

	localparam int PIX_PER_WORD = 8;
	localparam int FRAME_WORDS  = H_ACTIVE * V_ACTIVE / PIX_PER_WORD;
	localparam int ADDR_W       = 8;
	localparam int WORD_W       = 256;
	localparam int LANE_W       = WORD_W / PIX_PER_WORD; // 32-bit lanes
	localparam int LANE_SEL_W   = $clog2(PIX_PER_WORD);

	localparam int FIFO_DEPTH = 16;
	localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
	localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

	localparam int PIX_DIV = 2; // Clocks per pixel
	localparam int DIV_W   = $clog2(PIX_DIV);
	localparam int H_CNT_W = $clog2(H_TOTAL);
	localparam int V_CNT_W = $clog2(V_TOTAL);

	typedef logic [ADDR_W-1:0] mem_addr_t;
	typedef logic [WORD_W-1:0] mem_word_t;

	// Arbiter to frame store
	typedef struct packed {
		logic      we;
		mem_addr_t addr;
		mem_word_t wdata;
	} mem_req_t;

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} pixel_t;

	typedef struct packed {
		logic hsync;
		logic vsync;
		logic de;
	} sync_t;

endpackage
